// File: rtl/eq_pkg.sv
`default_nettype none

package eq_pkg;

    localparam int SAMPLE_W      = 16;
    // Signed Q2.14 coefficients
    localparam int COEF_W        = 16;
    localparam int COEF_FRAC     = 14;
    localparam int ACC_W         = 40;
    localparam int NUM_BANDS     = 3;
    localparam int TAPS_PER_BAND = 5;
    localparam int NUM_COEFS     = NUM_BANDS * TAPS_PER_BAND;
    localparam int COEF_IDX_W    = $clog2(NUM_COEFS);
    localparam int COEF_ONE      = 1 << COEF_FRAC;
    // Acceptance edge to output strobe
    localparam int EQ_LATENCY    = 17;
    // Width of the APB word index above the two byte address bits
    localparam int ADDR_W        = 6;
    localparam logic [ADDR_W-1:0] REG_CTRL = 6'd15;

    typedef struct packed {
        logic signed [COEF_W-1:0] b0;
        logic signed [COEF_W-1:0] b1;
        logic signed [COEF_W-1:0] b2;
        logic signed [COEF_W-1:0] a1;
        logic signed [COEF_W-1:0] a2;
    } biquad_coef_t;

    typedef struct packed {
        biquad_coef_t low;
        biquad_coef_t mid;
        biquad_coef_t high;
    } eq_coef_t;

    typedef enum logic [2:0] {
        TAP_B0,
        TAP_B1,
        TAP_B2,
        TAP_A1,
        TAP_A2
    } tap_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } ctrl_state_e;

    // One tap command with final_band set for the high band
    typedef struct packed {
        logic [1:0] band;
        tap_op_e    op;
        logic       first;
        logic       last;
        logic       final_band;
    } mac_op_t;

endpackage

`default_nettype wire

// File: rtl/eq_coef_regs.sv
`timescale 1ns/1ps
`default_nettype none

module eq_coef_regs (
    input  logic                      lmmi_clk_i,
    input  logic                      reset_n_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [eq_pkg::ADDR_W+1:0] paddr_i,
    input  logic [31:0]               pwdata_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    output eq_pkg::eq_coef_t          coef_o,
    output logic                      clear_req_o
);

    logic [eq_pkg::ADDR_W-1:0]                           idx;
    logic [eq_pkg::COEF_IDX_W-1:0]                       word;
    logic                                                access;
    logic                                                is_coef;
    // Index 0 in the top bits to match the eq_coef_t layout
    logic [0:eq_pkg::NUM_COEFS-1][eq_pkg::COEF_W-1:0]    bank_q;

    assign idx     = paddr_i[eq_pkg::ADDR_W+1:2];
    assign word    = idx[eq_pkg::COEF_IDX_W-1:0];
    assign access  = psel_i & penable_i;
    assign is_coef = (idx < eq_pkg::REG_CTRL);

    // Zero wait states
    assign pready_o    = 1'b1;
    assign pslverr_o   = access & (idx > eq_pkg::REG_CTRL);
    assign clear_req_o = access & pwrite_i & (idx == eq_pkg::REG_CTRL) & pwdata_i[0];
    assign coef_o      = bank_q;

    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            bank_q    <= '0;
            // Unity gain through the low band
            bank_q[0] <= eq_pkg::COEF_W'(eq_pkg::COEF_ONE);
        end else if (access && pwrite_i && is_coef) begin
            bank_q[word] <= pwdata_i[eq_pkg::COEF_W-1:0];
        end
    end

    // Control register and unmapped words read as zero
    always_comb begin
        prdata_o = '0;
        if (is_coef) begin
            prdata_o = {{(32 - eq_pkg::COEF_W){bank_q[word][eq_pkg::COEF_W-1]}}, bank_q[word]};
        end
    end

endmodule

`default_nettype wire

// File: rtl/eq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module eq_ctrl (
    input  logic            lmmi_clk_i,
    input  logic            reset_n_i,
    input  logic            sample_valid_i,
    input  logic            clear_req_i,
    output logic            busy_o,
    output eq_pkg::mac_op_t mac_op_o,
    output logic            mac_valid_o,
    output logic            x_latch_o,
    output logic            clear_o
);

    eq_pkg::ctrl_state_e state_q;
    // Tap counter as band and opcode
    logic [1:0]          band_q;
    eq_pkg::tap_op_e     op_q;
    logic                clr_pend_q;
    logic                idle;

    assign idle = (state_q == eq_pkg::ST_IDLE);

    // A clear takes the idle cycle and holds off acceptance
    assign clear_o     = idle & (clr_pend_q | clear_req_i);
    assign x_latch_o   = idle & sample_valid_i & ~clear_o;
    assign busy_o      = ~idle;
    assign mac_valid_o = (state_q == eq_pkg::ST_RUN);

    always_comb begin
        mac_op_o.band       = band_q;
        mac_op_o.op         = op_q;
        mac_op_o.first      = (op_q == eq_pkg::TAP_B0);
        mac_op_o.last       = (op_q == eq_pkg::TAP_A2);
        mac_op_o.final_band = (band_q == 2'(eq_pkg::NUM_BANDS - 1));
    end

    // Requests arriving mid-sample wait here
    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            clr_pend_q <= 1'b0;
        end else if (clear_o) begin
            clr_pend_q <= 1'b0;
        end else if (clear_req_i) begin
            clr_pend_q <= 1'b1;
        end
    end

    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            state_q <= eq_pkg::ST_IDLE;
            band_q  <= '0;
            op_q    <= eq_pkg::TAP_B0;
        end else begin
            case (state_q)
                eq_pkg::ST_IDLE: begin
                    if (x_latch_o) begin
                        state_q <= eq_pkg::ST_RUN;
                        band_q  <= '0;
                        op_q    <= eq_pkg::TAP_B0;
                    end
                end
                eq_pkg::ST_RUN: begin
                    if (mac_op_o.last) begin
                        op_q   <= eq_pkg::TAP_B0;
                        band_q <= band_q + 2'd1;
                        if (mac_op_o.final_band) begin
                            state_q <= eq_pkg::ST_DONE;
                        end
                    end else begin
                        op_q <= eq_pkg::tap_op_e'(op_q + 3'd1);
                    end
                end
                // MAC drains its last tap here
                eq_pkg::ST_DONE: state_q <= eq_pkg::ST_IDLE;
                default:         state_q <= eq_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/eq_band_state.sv
`timescale 1ns/1ps
`default_nettype none

module eq_band_state (
    input  logic                                               lmmi_clk_i,
    input  logic                                               reset_n_i,
    input  logic                                               clear_i,
    input  logic                                               x_latch_i,
    input  logic                                               x_shift_i,
    input  logic [eq_pkg::SAMPLE_W-1:0]                        sample_i,
    input  logic                                               y_wr_i,
    input  logic [1:0]                                         y_band_i,
    input  logic [eq_pkg::SAMPLE_W-1:0]                        y_value_i,
    output logic [eq_pkg::SAMPLE_W-1:0]                        x0_o,
    output logic [eq_pkg::SAMPLE_W-1:0]                        x1_o,
    output logic [eq_pkg::SAMPLE_W-1:0]                        x2_o,
    output logic [eq_pkg::NUM_BANDS-1:0][eq_pkg::SAMPLE_W-1:0] y1_o,
    output logic [eq_pkg::NUM_BANDS-1:0][eq_pkg::SAMPLE_W-1:0] y2_o
);

    // Input history shared by all bands
    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i || clear_i) begin
            x0_o <= '0;
            x1_o <= '0;
            x2_o <= '0;
        end else begin
            if (x_latch_i) begin
                x0_o <= sample_i;
            end
            if (x_shift_i) begin
                x1_o <= x0_o;
                x2_o <= x1_o;
            end
        end
    end

    // Output history per band
    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i || clear_i) begin
            y1_o <= '0;
            y2_o <= '0;
        end else if (y_wr_i) begin
            y1_o[y_band_i] <= y_value_i;
            y2_o[y_band_i] <= y1_o[y_band_i];
        end
    end

endmodule

`default_nettype wire

// File: rtl/eq_biquad_mac.sv
`timescale 1ns/1ps
`default_nettype none

module eq_biquad_mac (
    input  logic                                               lmmi_clk_i,
    input  logic                                               reset_n_i,
    input  eq_pkg::eq_coef_t                                   coef_i,
    input  eq_pkg::mac_op_t                                    mac_op_i,
    input  logic                                               mac_valid_i,
    input  logic [eq_pkg::SAMPLE_W-1:0]                        x0_i,
    input  logic [eq_pkg::SAMPLE_W-1:0]                        x1_i,
    input  logic [eq_pkg::SAMPLE_W-1:0]                        x2_i,
    input  logic [eq_pkg::NUM_BANDS-1:0][eq_pkg::SAMPLE_W-1:0] y1_i,
    input  logic [eq_pkg::NUM_BANDS-1:0][eq_pkg::SAMPLE_W-1:0] y2_i,
    output logic                                               y_wr_o,
    output logic [1:0]                                         y_band_o,
    output logic [eq_pkg::SAMPLE_W-1:0]                        y_value_o,
    output logic                                               x_shift_o,
    output logic [eq_pkg::SAMPLE_W-1:0]                        out_o,
    output logic                                               out_valid_o
);

    eq_pkg::biquad_coef_t                           band_coef;
    logic signed [eq_pkg::COEF_W-1:0]               coef_sel;
    logic signed [eq_pkg::SAMPLE_W-1:0]             operand;
    logic signed [eq_pkg::COEF_W+eq_pkg::SAMPLE_W-1:0] prod_q;
    eq_pkg::mac_op_t                                op_q;
    logic                                           valid_q;
    logic signed [eq_pkg::ACC_W-1:0]                prod_ext;
    logic signed [eq_pkg::ACC_W-1:0]                acc_q;
    logic signed [eq_pkg::ACC_W-1:0]                acc_next;
    logic signed [eq_pkg::SAMPLE_W+1:0]             sum_q;
    logic signed [eq_pkg::SAMPLE_W+1:0]             sum_next;
    logic signed [eq_pkg::SAMPLE_W-1:0]             band_y;

    // Clamp to the signed sample range
    function automatic logic [eq_pkg::SAMPLE_W-1:0] sat_sample(
        input logic signed [eq_pkg::ACC_W-1:0] v
    );
        if (v[eq_pkg::ACC_W-1:eq_pkg::SAMPLE_W-1] !=
            {(eq_pkg::ACC_W - eq_pkg::SAMPLE_W + 1){v[eq_pkg::ACC_W-1]}}) begin
            return v[eq_pkg::ACC_W-1] ? {1'b1, {(eq_pkg::SAMPLE_W-1){1'b0}}}
                                      : {1'b0, {(eq_pkg::SAMPLE_W-1){1'b1}}};
        end
        return v[eq_pkg::SAMPLE_W-1:0];
    endfunction

    // Coefficient and operand for the current tap
    always_comb begin
        case (mac_op_i.band)
            2'd0:    band_coef = coef_i.low;
            2'd1:    band_coef = coef_i.mid;
            default: band_coef = coef_i.high;
        endcase
        case (mac_op_i.op)
            eq_pkg::TAP_B0: begin
                coef_sel = band_coef.b0;
                operand  = x0_i;
            end
            eq_pkg::TAP_B1: begin
                coef_sel = band_coef.b1;
                operand  = x1_i;
            end
            eq_pkg::TAP_B2: begin
                coef_sel = band_coef.b2;
                operand  = x2_i;
            end
            eq_pkg::TAP_A1: begin
                coef_sel = band_coef.a1;
                operand  = y1_i[mac_op_i.band];
            end
            default: begin
                coef_sel = band_coef.a2;
                operand  = y2_i[mac_op_i.band];
            end
        endcase
    end

    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mac_valid_i;
        end
    end

    // Pipeline register in front of the accumulator
    always_ff @(posedge lmmi_clk_i) begin
        prod_q <= coef_sel * operand;
        op_q   <= mac_op_i;
    end

    // Feedback taps subtract
    always_comb begin
        prod_ext = eq_pkg::ACC_W'(prod_q);
        if (op_q.op == eq_pkg::TAP_A1 || op_q.op == eq_pkg::TAP_A2) begin
            prod_ext = -prod_ext;
        end
        acc_next = (op_q.first ? '0 : acc_q) + prod_ext;
        band_y   = sat_sample(acc_next >>> eq_pkg::COEF_FRAC);
        sum_next = ((op_q.band == 2'd0) ? '0 : sum_q) + (eq_pkg::SAMPLE_W + 2)'(band_y);
    end

    always_ff @(posedge lmmi_clk_i) begin
        if (valid_q) begin
            acc_q <= acc_next;
            if (op_q.last) begin
                sum_q <= sum_next;
            end
        end
    end

    // Band closes in the cycle after its last tap
    assign y_wr_o    = valid_q & op_q.last;
    assign y_band_o  = op_q.band;
    assign y_value_o = band_y;
    assign x_shift_o = y_wr_o & op_q.final_band;

    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            out_o       <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= x_shift_o;
            if (x_shift_o) begin
                out_o <= sat_sample(eq_pkg::ACC_W'(sum_next));
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/eq_top.sv
`timescale 1ns/1ps
`default_nettype none

module eq_top (
    input  logic                      lmmi_clk_i,
    input  logic                      reset_n_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [eq_pkg::ADDR_W+1:0] paddr_i,
    input  logic [31:0]               pwdata_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    input  logic [eq_pkg::SAMPLE_W-1:0] sample_i,
    input  logic                      sample_valid_i,
    output logic                      busy_o,
    output logic [eq_pkg::SAMPLE_W-1:0] out_o,
    output logic                      out_valid_o
);

    eq_pkg::eq_coef_t                               coef;
    eq_pkg::mac_op_t                                mac_op;
    logic                                           clear_req;
    logic                                           mac_valid;
    logic                                           x_latch;
    logic                                           x_shift;
    logic                                           clear;
    logic                                           y_wr;
    logic [1:0]                                     y_band;
    logic [eq_pkg::SAMPLE_W-1:0]                    y_value;
    logic [eq_pkg::SAMPLE_W-1:0]                    x0;
    logic [eq_pkg::SAMPLE_W-1:0]                    x1;
    logic [eq_pkg::SAMPLE_W-1:0]                    x2;
    logic [eq_pkg::NUM_BANDS-1:0][eq_pkg::SAMPLE_W-1:0] y1;
    logic [eq_pkg::NUM_BANDS-1:0][eq_pkg::SAMPLE_W-1:0] y2;

    eq_coef_regs regs_i (
        .lmmi_clk_i (lmmi_clk_i), .reset_n_i (reset_n_i),
        .psel_i     (psel_i),     .penable_i (penable_i),
        .pwrite_i   (pwrite_i),   .paddr_i   (paddr_i),
        .pwdata_i   (pwdata_i),   .prdata_o  (prdata_o),
        .pready_o   (pready_o),   .pslverr_o (pslverr_o),
        .coef_o     (coef),       .clear_req_o (clear_req)
    );

    eq_ctrl ctrl_i (
        .lmmi_clk_i     (lmmi_clk_i),     .reset_n_i   (reset_n_i),
        .sample_valid_i (sample_valid_i), .clear_req_i (clear_req),
        .busy_o         (busy_o),         .mac_op_o    (mac_op),
        .mac_valid_o    (mac_valid),      .x_latch_o   (x_latch),
        .clear_o        (clear)
    );

    eq_band_state state_i (
        .lmmi_clk_i (lmmi_clk_i), .reset_n_i (reset_n_i),
        .clear_i    (clear),      .x_latch_i (x_latch),
        .x_shift_i  (x_shift),    .sample_i  (sample_i),
        .y_wr_i     (y_wr),       .y_band_i  (y_band),
        .y_value_i  (y_value),
        .x0_o (x0), .x1_o (x1), .x2_o (x2),
        .y1_o (y1), .y2_o (y2)
    );

    eq_biquad_mac mac_i (
        .lmmi_clk_i  (lmmi_clk_i), .reset_n_i   (reset_n_i),
        .coef_i      (coef),       .mac_op_i    (mac_op),
        .mac_valid_i (mac_valid),
        .x0_i (x0), .x1_i (x1), .x2_i (x2),
        .y1_i (y1), .y2_i (y2),
        .y_wr_o      (y_wr),       .y_band_o    (y_band),
        .y_value_o   (y_value),    .x_shift_o   (x_shift),
        .out_o       (out_o),      .out_valid_o (out_valid_o)
    );

endmodule

`default_nettype wire

// File: tests/eq_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module eq_asserts (
    input logic lmmi_clk_i,
    input logic reset_n_i,
    input logic pready_i,
    input logic busy_i,
    input logic out_valid_i,
    input logic x_latch_i
);

    // Assertion failures so far
    int fail_count = 0;

    pready_high: assert property (@(posedge lmmi_clk_i) disable iff (!reset_n_i)
        pready_i)
        else begin
            $error("pready_o went low");
            fail_count++;
        end

    // Output strobe is a single-cycle pulse
    strobe_width: assert property (@(posedge lmmi_clk_i) disable iff (!reset_n_i)
        out_valid_i |=> !out_valid_i)
        else begin
            $error("out_valid_o held high for more than one cycle");
            fail_count++;
        end

    strobe_idle: assert property (@(posedge lmmi_clk_i) disable iff (!reset_n_i)
        out_valid_i |-> !busy_i)
        else begin
            $error("busy_o high during the output strobe");
            fail_count++;
        end

    strobe_latency: assert property (@(posedge lmmi_clk_i) disable iff (!reset_n_i)
        out_valid_i |-> $past(x_latch_i, eq_pkg::EQ_LATENCY))
        else begin
            $error("out_valid_o without an acceptance EQ_LATENCY cycles earlier");
            fail_count++;
        end

endmodule

bind eq_top eq_asserts asserts_i (
    .lmmi_clk_i  (lmmi_clk_i),
    .reset_n_i   (reset_n_i),
    .pready_i    (pready_o),
    .busy_i      (busy_o),
    .out_valid_i (out_valid_o),
    .x_latch_i   (x_latch)
);

`default_nettype wire

// File: tests/eq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eq_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int N_SAMPLES       = 320;
    localparam int WATCHDOG_CYCLES = N_SAMPLES * (eq_pkg::EQ_LATENCY + 4) + 2000;
    localparam int unsigned SEED   = 32'haa61cb79;

    logic                          clk = 1'b0;
    logic                          reset_n;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [eq_pkg::ADDR_W+1:0]     paddr;
    logic [31:0]                   pwdata;
    logic [31:0]                   prdata;
    logic                          pready;
    logic                          pslverr;
    logic [eq_pkg::SAMPLE_W-1:0]   sample;
    logic                          sample_valid;
    logic                          busy;
    logic [eq_pkg::SAMPLE_W-1:0]   out;
    logic                          out_valid;

    // Reference model state
    logic signed [15:0] ref_coef [eq_pkg::NUM_COEFS];
    logic signed [15:0] ref_x1;
    logic signed [15:0] ref_x2;
    logic signed [15:0] ref_y1 [eq_pkg::NUM_BANDS];
    logic signed [15:0] ref_y2 [eq_pkg::NUM_BANDS];

    logic [15:0] exp_q [$];
    int          acc_cycle_q [$];
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_start = 0;

    eq_top dut_i (
        .lmmi_clk_i     (clk),
        .reset_n_i      (reset_n),
        .psel_i         (psel),
        .penable_i      (penable),
        .pwrite_i       (pwrite),
        .paddr_i        (paddr),
        .pwdata_i       (pwdata),
        .prdata_o       (prdata),
        .pready_o       (pready),
        .pslverr_o      (pslverr),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .busy_o         (busy),
        .out_o          (out),
        .out_valid_o    (out_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    function automatic logic signed [15:0] sat16(input longint v);
        if (v > 32767) begin
            return 16'sh7fff;
        end
        if (v < -32768) begin
            return 16'sh8000;
        end
        return v[15:0];
    endfunction

    // One sample through the three biquads with history kept in the model
    function automatic logic [15:0] eq_ref_step(input logic signed [15:0] x);
        longint             acc;
        longint             sum;
        logic signed [15:0] y;
        int                 b;
        int                 k;
        sum = 0;
        for (b = 0; b < eq_pkg::NUM_BANDS; b++) begin
            k   = b * eq_pkg::TAPS_PER_BAND;
            acc = longint'(ref_coef[k]) * longint'(x)
                + longint'(ref_coef[k + 1]) * longint'(ref_x1)
                + longint'(ref_coef[k + 2]) * longint'(ref_x2)
                - longint'(ref_coef[k + 3]) * longint'(ref_y1[b])
                - longint'(ref_coef[k + 4]) * longint'(ref_y2[b]);
            y         = sat16(acc >>> eq_pkg::COEF_FRAC);
            ref_y2[b] = ref_y1[b];
            ref_y1[b] = y;
            sum       = sum + longint'(y);
        end
        ref_x2 = ref_x1;
        ref_x1 = x;
        return sat16(sum);
    endfunction

    function automatic void ref_clear();
        int b;
        ref_x1 = '0;
        ref_x2 = '0;
        for (b = 0; b < eq_pkg::NUM_BANDS; b++) begin
            ref_y1[b] = '0;
            ref_y2[b] = '0;
        end
    endfunction

    task automatic log_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // Setup phase followed by one access phase
    task automatic apb_access(input logic write, input int idx, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = (eq_pkg::ADDR_W + 2)'(idx * 4);
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) begin
            log_error("pready_o was low in the APB access phase");
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input int idx, input logic [31:0] wdata, output logic err);
        logic [31:0] unused_rdata;
        apb_access(1'b1, idx, wdata, unused_rdata, err);
    endtask

    task automatic apb_read(input int idx, output logic [31:0] rdata, output logic err);
        apb_access(1'b0, idx, 32'h0, rdata, err);
    endtask

    task automatic set_coef(input int idx, input logic [15:0] v);
        logic err;
        apb_write(idx, {{16{v[15]}}, v}, err);
        if (err) begin
            log_error($sformatf("pslverr_o raised on a write to coefficient %0d", idx));
        end
        ref_coef[idx] = v;
    endtask

    // Feedforward within +-0.5 and feedback within +-0.25 keep every band stable
    task automatic random_coefs();
        int i;
        for (i = 0; i < eq_pkg::NUM_COEFS; i++) begin
            if (i % eq_pkg::TAPS_PER_BAND < 3) begin
                set_coef(i, 16'($urandom_range(16383)) - 16'd8192);
            end else begin
                set_coef(i, 16'($urandom_range(8191)) - 16'd4096);
            end
        end
    endtask

    // Strobe is held until busy_o shows the sample was taken
    task automatic send_sample(input logic [15:0] x);
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        sample       = x;
        sample_valid = 1'b1;
        @(negedge clk);
        while (!busy) begin
            @(negedge clk);
        end
        sample_valid = 1'b0;
        exp_q.push_back(eq_ref_step(x));
        acc_cycle_q.push_back(cycle);
    endtask

    task automatic drop_strobe(input logic [15:0] x);
        @(negedge clk);
        if (!busy) begin
            log_error("Core went idle before the strobe that should be dropped");
        end else begin
            sample       = x;
            sample_valid = 1'b1;
            @(negedge clk);
            sample_valid = 1'b0;
        end
    endtask

    // The edge after this negedge samples the strobe
    task automatic compare_outputs();
        logic [15:0] exp_val;
        int          acc_cycle;
        forever begin
            @(negedge clk);
            if (out_valid && exp_q.size() == 0) begin
                log_error($sformatf("Output strobe with no accepted sample, out_o %h", out));
            end else if (out_valid) begin
                exp_val   = exp_q.pop_front();
                acc_cycle = acc_cycle_q.pop_front();
                checks++;
                if (out !== exp_val) begin
                    log_error($sformatf("[FAIL] out_o: expected %h, got %h", exp_val, out));
                end
                if (cycle + 1 - acc_cycle != eq_pkg::EQ_LATENCY) begin
                    log_error($sformatf("Output came %0d cycles after acceptance, not %0d",
                                        cycle + 1 - acc_cycle, eq_pkg::EQ_LATENCY));
                end
            end
        end
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        tests++;
        $display("[DONE] %s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] exp32;
        logic [15:0] val;
        logic        err;
        int          i;
        int unsigned rnd;

        rnd          = $urandom(SEED);
        reset_n      = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        sample       = '0;
        sample_valid = 1'b0;
        ref_clear();
        for (i = 0; i < eq_pkg::NUM_COEFS; i++) begin
            ref_coef[i] = '0;
        end
        // 1.0 in Q2.14 on the low band b0
        ref_coef[0] = 16'sh4000;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        fork
            compare_outputs();
        join_none

        for (i = 0; i <= eq_pkg::NUM_COEFS; i++) begin
            apb_read(i, rdata, err);
            exp32 = (i == 0) ? 32'h0000_4000 : 32'h0;
            if (rdata !== exp32 || err) begin
                log_error($sformatf("[FAIL] prdata_o[%0d]: expected %h, got %h, pslverr_o %h",
                                    i, exp32, rdata, err));
            end
        end
        repeat (20) send_sample(16'($urandom));
        finish_test("reset defaults");

        for (i = 0; i < eq_pkg::NUM_COEFS; i++) begin
            val = 16'($urandom);
            set_coef(i, val);
            apb_read(i, rdata, err);
            if (rdata !== {{16{val[15]}}, val}) begin
                log_error($sformatf("[FAIL] prdata_o[%0d]: expected %h, got %h",
                                    i, {{16{val[15]}}, val}, rdata));
            end
        end
        apb_write(20, 32'h0000_5a5a, err);
        if (!err) begin
            log_error("pslverr_o stayed low on a write to index 20");
        end
        apb_read(20, rdata, err);
        if (!err) begin
            log_error("pslverr_o stayed low on a read of index 20");
        end
        for (i = 0; i < eq_pkg::NUM_COEFS; i++) begin
            apb_read(i, rdata, err);
            exp32 = {{16{ref_coef[i][15]}}, ref_coef[i]};
            if (rdata !== exp32) begin
                log_error($sformatf("[FAIL] prdata_o[%0d]: expected %h, got %h",
                                    i, exp32, rdata));
            end
        end
        finish_test("register access");

        random_coefs();
        repeat (200) send_sample(16'($urandom));
        finish_test("random filtering");

        // Gain of about 4 per band
        for (i = 0; i < eq_pkg::NUM_COEFS; i++) begin
            set_coef(i, (i % eq_pkg::TAPS_PER_BAND < 2) ? 16'h7fff : 16'h0000);
        end
        repeat (6) send_sample(16'h7fff);
        repeat (6) send_sample(16'h8000);
        repeat (8) send_sample(16'($urandom));
        finish_test("saturation");

        random_coefs();
        repeat (10) begin
            send_sample(16'($urandom));
            drop_strobe(16'($urandom));
        end
        repeat (10) send_sample(16'($urandom));
        finish_test("dropped strobes");

        repeat (10) send_sample(16'($urandom));
        finish_test("history before clear");
        apb_write(int'(eq_pkg::REG_CTRL), 32'h1, err);
        ref_clear();
        repeat (10) send_sample(16'($urandom));
        // Clear lands mid-sample and is served once the core is idle
        send_sample(16'($urandom));
        apb_write(int'(eq_pkg::REG_CTRL), 32'h1, err);
        ref_clear();
        repeat (10) send_sample(16'($urandom));
        finish_test("history clear");

        $display("Tests run: %0d, outputs checked: %0d, errors: %0d, assertion failures: %0d",
                 tests, checks, errors, dut_i.asserts_i.fail_count);
        if (errors == 0 && dut_i.asserts_i.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: eq_top.f
rtl/eq_pkg.sv
rtl/eq_coef_regs.sv
rtl/eq_ctrl.sv
rtl/eq_band_state.sv
rtl/eq_biquad_mac.sv
rtl/eq_top.sv
tests/eq_asserts.sv
tests/eq_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module eq_tb -f eq_top.f -o eq_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/eq_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
